/* Bender.yml */
package:
  name: servo_pwm

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/servo_pkg.sv
      - rtl/servo_wr_if.sv
      - rtl/servo_ch_if.sv
      - rtl/servo_bus_decoder.sv
      - rtl/servo_reg_bank.sv
      - rtl/servo_pwm_gen.sv
      - rtl/servo_pwm_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/servo_pwm_tb.sv

/* filelist.f */
+incdir+rtl
rtl/servo_pkg.sv
rtl/servo_wr_if.sv
rtl/servo_ch_if.sv
rtl/servo_bus_decoder.sv
rtl/servo_reg_bank.sv
rtl/servo_pwm_gen.sv
rtl/servo_pwm_top.sv
verif/servo_pwm_tb.sv

/* rtl/servo_bus_decoder.sv */
// Servo bus decoder
// Matches bus writes against the servo register block and registers
// the decoded channel, register select and data

`timescale 1ns/1ps
`default_nettype none

`include "servo_cfg.svh"

module servo_bus_decoder import servo_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        wr_en,
   input  servo_addr_t wr_addr,
   input  servo_data_t wr_data,
   servo_wr_if.source  wr
);

   localparam servo_addr_t BASE_ADDR = `SERVO_BASE_ADDR;

   // Address layout: [tag | channel | select]
   localparam int CH_LSB  = $bits(servo_reg_t);
   localparam int TAG_LSB = CH_LSB + $bits(servo_ch_t);

   logic       tag_match;
   logic       hit;
   servo_ch_t  addr_ch;
   servo_reg_t addr_sel;

   assign addr_ch   = wr_addr[TAG_LSB-1:CH_LSB];
   assign addr_sel  = wr_addr[CH_LSB-1:0];
   assign tag_match = (wr_addr[`SERVO_ADDR_W-1:TAG_LSB] == BASE_ADDR[`SERVO_ADDR_W-1:TAG_LSB]);

   // Reserved word 3 is dropped here, so the bank never sees it
   assign hit = wr_en && tag_match && (addr_sel != 2'd3);

   // Strobe
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr.valid <= 1'b0;
      end
      else
      begin
         wr.valid <= hit;
      end
   end

   // Payload, held between writes
   always_ff @(posedge clk)
   begin
      if (hit)
      begin
         wr.ch   <= addr_ch;
         wr.sel  <= addr_sel;
         wr.data <= wr_data;
      end
   end

endmodule

`default_nettype wire

/* rtl/servo_cfg.svh */
// Servo PWM configuration
// Channel count, bus widths and the register block's base address

`ifndef SERVO_CFG_SVH
`define SERVO_CFG_SVH

// Number of PWM channels
`define SERVO_NUM_CH 8

// Bus data width, also the width of the period counter
`define SERVO_DATA_W 32

// Bus word address width
`define SERVO_ADDR_W 16

// Word address of channel 0 register 0, aligned to 32 words
`define SERVO_BASE_ADDR 16'h0100

`endif

/* rtl/servo_ch_if.sv */
// Per-channel PWM settings
// Period, on-time and enable for all channels plus restart pulses

`timescale 1ns/1ps
`default_nettype none

`include "servo_cfg.svh"

interface servo_ch_if import servo_pkg::*; ();

   servo_data_t               period  [`SERVO_NUM_CH];
   servo_data_t               ontime  [`SERVO_NUM_CH];
   logic [`SERVO_NUM_CH-1:0]  enable;
   // Bit n pulses when channel n's new settings first appear
   logic [`SERVO_NUM_CH-1:0]  restart;

   // Register bank side
   modport source (
      output period,
      output ontime,
      output enable,
      output restart
   );

   // Generator side
   modport sink (
      input period,
      input ontime,
      input enable,
      input restart
   );

endinterface

`default_nettype wire

/* rtl/servo_pkg.sv */
// Servo PWM package
// Vector types shared by the bus decoder, register bank and generators

`default_nettype none

package servo_pkg;

`include "servo_cfg.svh"

   // Period, on-time, bus data and counter value
   typedef logic [`SERVO_DATA_W-1:0] servo_data_t;

   // Bus word address
   typedef logic [`SERVO_ADDR_W-1:0] servo_addr_t;

   // Channel index
   typedef logic [$clog2(`SERVO_NUM_CH)-1:0] servo_ch_t;

   // Register select within a channel
   // 0 period, 1 on-time, 2 config, 3 reserved
   typedef logic [1:0] servo_reg_t;

endpackage

`default_nettype wire

/* rtl/servo_pwm_gen.sv */
// Servo PWM generator
// One channel's period counter and output level, gated by enable

`timescale 1ns/1ps
`default_nettype none

module servo_pwm_gen import servo_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  servo_data_t period,
   input  servo_data_t ontime,
   input  logic        enable,
   input  logic        restart,
   output logic        pwm
);

   servo_data_t count;
   logic        level;

   // Count runs 0..period, high while count <= ontime
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count <= '0;
         level <= 1'b0;
      end
      else if (restart)
      begin
         // New settings, start a fresh cycle
         count <= '0;
         level <= 1'b1;
      end
      else if (count == period)
      begin
         count <= '0;
         level <= 1'b1;
      end
      else if (count == ontime)
      begin
         // Falls after the on-time count, unless the wrap wins above
         count <= count + 1'b1;
         level <= 1'b0;
      end
      else
      begin
         count <= count + 1'b1;
      end
   end

   // Enable gates the level directly, counter keeps running
   assign pwm = level & enable;

endmodule

`default_nettype wire

/* rtl/servo_pwm_top.sv */
// Eight-channel servo PWM driver
// Bus decoder feeds the register bank, which drives one PWM
// generator per channel

`timescale 1ns/1ps
`default_nettype none

`include "servo_cfg.svh"

module servo_pwm_top import servo_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     wr_en,
   input  servo_addr_t              wr_addr,
   input  servo_data_t              wr_data,
   output logic [`SERVO_NUM_CH-1:0] pwm_out
);

   servo_wr_if wr_bus ();
   servo_ch_if ch_bus ();

   servo_bus_decoder u_decoder (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .wr      (wr_bus.source)
   );

   servo_reg_bank u_bank (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (wr_bus.sink),
      .ch    (ch_bus.source)
   );

   // One generator per channel, each on its own slice of the settings
   for (genvar i = 0; i < `SERVO_NUM_CH; i++)
   begin : g_ch
      servo_pwm_gen u_gen (
         .clk     (clk),
         .rst_n   (rst_n),
         .period  (ch_bus.period[i]),
         .ontime  (ch_bus.ontime[i]),
         .enable  (ch_bus.enable[i]),
         .restart (ch_bus.restart[i]),
         .pwm     (pwm_out[i])
      );
   end

endmodule

`default_nettype wire

/* rtl/servo_reg_bank.sv */
// Servo register bank
// Stores period, on-time and enable per channel and pulses the
// channel's restart bit whenever one of its registers is written

`timescale 1ns/1ps
`default_nettype none

`include "servo_cfg.svh"

module servo_reg_bank import servo_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   servo_wr_if.sink   wr,
   servo_ch_if.source ch
);

   // Settings registers
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `SERVO_NUM_CH; i++)
         begin
            ch.period[i] <= '0;
            ch.ontime[i] <= '0;
         end
         ch.enable <= '0;
      end
      else if (wr.valid)
      begin
         for (int i = 0; i < `SERVO_NUM_CH; i++)
         begin
            if (wr.ch == servo_ch_t'(i))
            begin
               case (wr.sel)
                  2'd0:
                  begin
                     ch.period[i] <= wr.data;
                  end
                  2'd1:
                  begin
                     ch.ontime[i] <= wr.data;
                  end
                  default:
                  begin
                     // Config, only the enable bit is kept
                     ch.enable[i] <= wr.data[0];
                  end
               endcase
            end
         end
      end
   end

   // Restart pulse, same cycle the new setting appears
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ch.restart <= '0;
      end
      else
      begin
         ch.restart <= '0;
         if (wr.valid)
         begin
            ch.restart[wr.ch] <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/servo_wr_if.sv */
// Decoded register write
// One-cycle write strobe with channel, register select and data

`timescale 1ns/1ps
`default_nettype none

interface servo_wr_if import servo_pkg::*; ();

   // Write strobe, one cycle per accepted bus write
   logic        valid;
   // Target channel and register, only meaningful with valid
   servo_ch_t   ch;
   servo_reg_t  sel;
   servo_data_t data;

   // Decoder side
   modport source (
      output valid,
      output ch,
      output sel,
      output data
   );

   // Register bank side
   modport sink (
      input valid,
      input ch,
      input sel,
      input data
   );

endinterface

`default_nettype wire

/* verif/servo_pwm_tb.sv */
// Servo PWM testbench
// Directed and random bus writes checked every cycle against a
// reference model of the decode, register and generator rules

`timescale 1ns/1ps
`default_nettype none

`include "servo_cfg.svh"

module servo_pwm_tb import servo_pkg::*; ();

   localparam int NCH          = `SERVO_NUM_CH;
   localparam int SEED         = 83879;
   localparam int RAND_WRITES  = 400;
   localparam int MAX_GAP      = 5;
   localparam int DIRECTED_CYC = 600;
   localparam int PLANNED_CYC  = 3 + 20 + DIRECTED_CYC + RAND_WRITES * (MAX_GAP + 1) + 30;
   localparam int TIMEOUT_CYC  = PLANNED_CYC + PLANNED_CYC / 5;
   localparam int WAIT_LIMIT   = 200;
   // Address bits above bit 4 select the block
   localparam int TAG_LSB      = 5;
   localparam servo_addr_t BASE_ADDR = `SERVO_BASE_ADDR;

   logic           clk;
   logic           rst_n;
   logic           wr_en;
   servo_addr_t    wr_addr;
   servo_data_t    wr_data;
   logic [NCH-1:0] pwm_out;

   // Model copy of the write sampled at the last edge
   logic           p_valid;
   servo_ch_t      p_ch;
   servo_reg_t     p_sel;
   servo_data_t    p_data;
   // Model channel settings and generator state
   servo_data_t    m_period [NCH];
   servo_data_t    m_ontime [NCH];
   logic [NCH-1:0] m_enable;
   logic [NCH-1:0] m_restart;
   servo_data_t    m_count  [NCH];
   logic [NCH-1:0] m_level;

   int unsigned    seed_val;
   int             cycle_cnt = 0;

   servo_pwm_top u_servo_pwm_top (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .pwm_out (pwm_out)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #4 clk = ~clk;
      end
   end

   // Hit on registers 0 to 2 of any channel
   function automatic logic addr_hit(servo_addr_t addr);
      return (addr[`SERVO_ADDR_W-1:TAG_LSB] == BASE_ADDR[`SERVO_ADDR_W-1:TAG_LSB])
             && (addr[1:0] != 2'd3);
   endfunction

   // Reference model stepped on every rising edge
   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         p_valid   = 1'b0;
         m_enable  = '0;
         m_restart = '0;
         m_level   = '0;
         for (int i = 0; i < NCH; i++)
         begin
            m_period[i] = '0;
            m_ontime[i] = '0;
            m_count[i]  = '0;
         end
      end
      else
      begin
         // Generators see the settings from before this edge
         for (int i = 0; i < NCH; i++)
         begin
            if (m_restart[i] || m_count[i] == m_period[i])
            begin
               m_count[i] = '0;
               m_level[i] = 1'b1;
            end
            else
            begin
               if (m_count[i] == m_ontime[i])
               begin
                  m_level[i] = 1'b0;
               end
               m_count[i] = m_count[i] + 1;
            end
         end
         // Settings land one edge after the decode
         m_restart = '0;
         if (p_valid)
         begin
            if (p_sel == 2'd0)
            begin
               m_period[p_ch] = p_data;
            end
            else if (p_sel == 2'd1)
            begin
               m_ontime[p_ch] = p_data;
            end
            else
            begin
               m_enable[p_ch] = p_data[0];
            end
            m_restart[p_ch] = 1'b1;
         end
         p_valid = wr_en && addr_hit(wr_addr);
         if (p_valid)
         begin
            p_ch   = wr_addr[4:2];
            p_sel  = wr_addr[1:0];
            p_data = wr_data;
         end
      end
   end

   task automatic check_pwm(string name, logic [NCH-1:0] actual, logic [NCH-1:0] expected);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, actual, expected);
         $display("Test FAILED");
         $fatal(1, "output mismatch");
      end
   endtask

   task automatic check_data(string name, servo_data_t actual, servo_data_t expected);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
         $display("Test FAILED");
         $fatal(1, "measurement mismatch");
      end
   endtask

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1, "run aborted");
   endtask

   // Compare all outputs on the falling edge
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         check_pwm("pwm_out", pwm_out, m_level & m_enable);
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYC)
      begin
         $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYC);
         $display("Test FAILED");
         $fatal(1, "cycle limit reached");
      end
   end

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic bus_write(servo_addr_t addr, servo_data_t data);
      wr_en   = 1'b1;
      wr_addr = addr;
      wr_data = data;
      tick();
      wr_en   = 1'b0;
   endtask

   task automatic wr_reg(servo_ch_t ch, servo_reg_t sel, servo_data_t data);
      bus_write(BASE_ADDR + servo_addr_t'({ch, sel}), data);
   endtask

   // Counts edges until the next low-to-high change of one channel
   task automatic wait_rise(input int ch, output int waited);
      waited = 0;
      while (pwm_out[ch] && waited < WAIT_LIMIT)
      begin
         tick();
         waited++;
      end
      while (!pwm_out[ch] && waited < WAIT_LIMIT)
      begin
         tick();
         waited++;
      end
      if (waited >= WAIT_LIMIT)
      begin
         fail_run($sformatf("Channel %0d never rose within %0d cycles", ch, WAIT_LIMIT));
      end
   endtask

   task automatic wait_fall(input int ch);
      int waited;
      waited = 0;
      while (pwm_out[ch] && waited < WAIT_LIMIT)
      begin
         tick();
         waited++;
      end
      if (waited >= WAIT_LIMIT)
      begin
         fail_run($sformatf("Channel %0d never fell within %0d cycles", ch, WAIT_LIMIT));
      end
   endtask

   // High time and full cycle length of the next complete pulse
   task automatic measure_pulse(input int ch, output servo_data_t high_t,
                                output servo_data_t cyc_t);
      int waited;
      wait_rise(ch, waited);
      high_t = 0;
      while (pwm_out[ch] && high_t < WAIT_LIMIT)
      begin
         tick();
         high_t++;
      end
      cyc_t = high_t;
      while (!pwm_out[ch] && cyc_t < WAIT_LIMIT)
      begin
         tick();
         cyc_t++;
      end
   endtask

   task automatic count_high(input int ch, input int cycles, output servo_data_t n);
      n = 0;
      repeat (cycles)
      begin
         tick();
         if (pwm_out[ch])
         begin
            n++;
         end
      end
   endtask

   task automatic run_random();
      servo_addr_t addr;
      servo_data_t data;
      servo_ch_t   ch;
      servo_reg_t  sel;
      for (int n = 0; n < RAND_WRITES; n++)
      begin
         ch  = servo_ch_t'($urandom_range(0, NCH - 1));
         sel = servo_reg_t'($urandom_range(0, 3));
         if (sel == 2'd0)
         begin
            data = $urandom_range(0, 40);
         end
         else if (sel == 2'd1)
         begin
            data = $urandom_range(0, 45);
         end
         else
         begin
            data = $urandom_range(0, 3);
         end
         addr = BASE_ADDR + servo_addr_t'({ch, sel});
         // About one write in five misses the block
         if ($urandom_range(0, 4) == 0)
         begin
            addr = servo_addr_t'($urandom);
            if (addr[`SERVO_ADDR_W-1:TAG_LSB] == BASE_ADDR[`SERVO_ADDR_W-1:TAG_LSB])
            begin
               addr[10] = ~addr[10];
            end
         end
         bus_write(addr, data);
         repeat ($urandom_range(0, MAX_GAP)) tick();
      end
   endtask

   initial
   begin
      servo_data_t hi_t;
      servo_data_t cyc_t;
      servo_data_t lat;
      int          waited;
      seed_val = $urandom(SEED);
      rst_n    = 1'b0;
      wr_en    = 1'b0;
      wr_addr  = '0;
      wr_data  = '0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Idle after reset
      repeat (20) tick();
      check_pwm("pwm_out", pwm_out, '0);

      // Steady pulse train on channel 3
      wr_reg(3, 2'd0, 20);
      wr_reg(3, 2'd1, 4);
      wr_reg(3, 2'd2, 1);
      // The enable write stretches the first pulse by one cycle
      tick();
      measure_pulse(3, hi_t, cyc_t);
      check_data("ch3 high time", hi_t, 5);
      check_data("ch3 cycle length", cyc_t, 21);

      // New on-time written while low raises the output two edges later
      wait_fall(3);
      wr_reg(3, 2'd1, 6);
      lat = 0;
      while (!pwm_out[3] && lat < WAIT_LIMIT)
      begin
         tick();
         lat++;
      end
      check_data("ch3 write to rise latency", lat, 2);
      measure_pulse(3, hi_t, cyc_t);
      check_data("ch3 high time", hi_t, 7);
      check_data("ch3 cycle length", cyc_t, 21);

      // On-time at or past the period holds the output high
      wr_reg(3, 2'd1, 20);
      tick();
      count_high(3, 60, hi_t);
      check_data("ch3 high cycles", hi_t, 60);
      wr_reg(3, 2'd1, 33);
      tick();
      count_high(3, 60, hi_t);
      check_data("ch3 high cycles", hi_t, 60);

      // Disabled channel stays low
      wr_reg(3, 2'd2, 0);
      tick();
      count_high(3, 60, hi_t);
      check_data("ch3 high cycles", hi_t, 0);

      // Writes outside the block or to register 3 must not restart
      wr_reg(3, 2'd1, 4);
      wr_reg(3, 2'd2, 1);
      // Skip the first pulse, which the enable write stretches
      tick();
      wait_rise(3, waited);
      repeat (6) tick();
      bus_write(BASE_ADDR + 16'h0020, 32'h5);
      wr_reg(3, 2'd3, 32'h1);
      wait_rise(3, waited);
      check_data("ch3 cycle length", servo_data_t'(waited + 8), 21);

      run_random();
      repeat (30) tick();
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire
